// File: common/cam_settings.svh
// ##########################################################################
// camera to display subsystem settings
// image size, display scale, reduced raster timing, colour swap
// ##########################################################################
`ifndef CAM_SETTINGS_SVH
`define CAM_SETTINGS_SVH

`define IMG_COLS     80                         // captured image width
`define IMG_ROWS     60                         // captured image height
`define IMG_PXLS     (`IMG_COLS * `IMG_ROWS)    // 4800 pixels
`define NB_IMG_ADDR  13                         // 2^13 covers 4800
`define IMG_SCALE    2                          // display upscale

// horizontal timing, in clocks
`define H_VIS   160
`define H_FP    4
`define H_SYNC  8
`define H_BP    4
// vertical timing, in lines
`define V_VIS   120
`define V_FP    2
`define V_SYNC  2
`define V_BP    2

`define SWAP_R_B 0   // 1: red and blue nibbles swapped on capture

`endif

// File: common/cam_pkg.sv
// ##########################################################################
// camera to display shared types
// pixel word, buffer address and raster counters
// ##########################################################################
`include "cam_settings.svh"

package cam_pkg;

  // rgb444 pixel as held in the frame buffer
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } pixel_t;

  // frame buffer address, one entry per pixel
  typedef logic [`NB_IMG_ADDR-1:0] img_addr_t;

  // raster position counters
  // 10 bits leaves room for larger modes than the reduced one
  typedef logic [9:0] col_t;
  typedef logic [9:0] row_t;

endpackage

// File: common/vga_timing_if.sv
// ##########################################################################
// raster timing bundle
// position and sync levels from the sync generator to the display
// ##########################################################################
`timescale 1ns/1ps

interface vga_timing_if;

  logic          visible;  // inside active area
  logic          hsync;    // active low
  logic          vsync;    // active low
  cam_pkg::col_t col;
  cam_pkg::row_t row;

  // sync generator side
  modport src (
    output visible, hsync, vsync, col, row
  );

  // display side
  modport snk (
    input visible, hsync, vsync, col, row
  );

endinterface

// File: capture/ov7670_capture.sv
// ##########################################################################
// ov7670 pixel bus capture
// syncs the camera bus, builds rgb444 pixels from byte pairs,
// writes them to the frame buffer and counts finished frames
// ##########################################################################
`timescale 1ns/1ps
`include "cam_settings.svh"

module ov7670_capture (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               pclk,
  input  logic               href,
  input  logic               vsync,
  input  logic [7:0]         data,
  output logic               wr_en,
  output cam_pkg::img_addr_t wr_addr,
  output cam_pkg::pixel_t    wr_data,
  output logic [7:0]         frame_cnt
);

  localparam cam_pkg::img_addr_t pxls = cam_pkg::img_addr_t'(`IMG_PXLS);
  localparam bit swap_rb = (`SWAP_R_B != 0);

  logic [1:0] pclk_sync, href_sync, vsync_sync;  // two flop chains, [1] is safe
  logic [7:0] data_s1, data_s2;
  logic       pclk_q, vsync_q;                   // edge detect stage
  logic       pclk_rise, vsync_rise;
  logic       byte_ph;      // 0: first byte (red), 1: second byte (green/blue)
  logic [3:0] red_nib;      // red held from first byte
  logic       written;      // a pixel went in since last vsync

  assign pclk_rise  = pclk_sync[1] & ~pclk_q;
  assign vsync_rise = vsync_sync[1] & ~vsync_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pclk_sync  <= '0;
      href_sync  <= '0;
      vsync_sync <= '0;
      pclk_q     <= 1'b0;
      vsync_q    <= 1'b0;
    end else begin
      pclk_sync  <= {pclk_sync[0], pclk};
      href_sync  <= {href_sync[0], href};
      vsync_sync <= {vsync_sync[0], vsync};
      pclk_q     <= pclk_sync[1];
      vsync_q    <= vsync_sync[1];
    end
  end

  // data is stable around pclk rise, same two stages as pclk
  always_ff @(posedge clk) begin
    data_s1 <= data;
    data_s2 <= data_s1;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      byte_ph   <= 1'b0;
      wr_en     <= 1'b0;
      wr_addr   <= '0;
      written   <= 1'b0;
      frame_cnt <= '0;
    end else begin
      wr_en <= 1'b0;  // single cycle pulse
      if (vsync_sync[1]) begin
        byte_ph <= 1'b0;
        wr_addr <= '0;
        if (vsync_rise) begin
          if (written)
            frame_cnt <= frame_cnt + 8'd1;  // empty frames don't count
          written <= 1'b0;
        end
      end else begin
        if (wr_en)
          wr_addr <= wr_addr + 1'b1;  // after the write, next pixel
        if (!href_sync[1]) begin
          byte_ph <= 1'b0;  // realign at each line start
        end else if (pclk_rise) begin
          byte_ph <= ~byte_ph;
          if (byte_ph && (wr_addr < pxls)) begin  // overflow pixels dropped
            wr_en   <= 1'b1;
            written <= 1'b1;
          end
        end
      end
    end
  end

  // pixel assembly
  always_ff @(posedge clk) begin
    if (pclk_rise && href_sync[1]) begin
      if (!byte_ph) begin
        red_nib <= data_s2[3:0];
      end else begin
        wr_data.red   <= swap_rb ? data_s2[3:0] : red_nib;
        wr_data.green <= data_s2[7:4];
        wr_data.blue  <= swap_rb ? red_nib : data_s2[3:0];
      end
    end
  end

  a_wr_in_range : assert property (@(posedge clk) disable iff (!arst_n)
    wr_en |-> (wr_addr < pxls))
    else $error("capture write past end of frame buffer");

  a_wr_single : assert property (@(posedge clk) disable iff (!arst_n)
    wr_en |=> !wr_en)
    else $error("capture write pulse longer than one cycle");

endmodule

// File: design/frame_buffer.sv
// ##########################################################################
// frame buffer
// one pixel per entry, write port from capture, registered read for display
// ##########################################################################
`timescale 1ns/1ps
`include "cam_settings.svh"

module frame_buffer (
  input  logic               clk,
  input  logic               wr_en,
  input  cam_pkg::img_addr_t wr_addr,
  input  cam_pkg::pixel_t    wr_data,
  input  cam_pkg::img_addr_t rd_addr,
  output cam_pkg::pixel_t    rd_data
);

  cam_pkg::pixel_t mem [0:`IMG_PXLS-1];  // maps to block ram

  // write side, capture never goes past the last entry
  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  // read side, data one clock after address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: display/vga_sync.sv
// ##########################################################################
// raster sync generator
// pixel and line counters with active low syncs and visible flag
// ##########################################################################
`timescale 1ns/1ps
`include "cam_settings.svh"

module vga_sync (
  input  logic         clk,
  input  logic         arst_n,
  vga_timing_if.src    tim
);

  localparam cam_pkg::col_t h_vis   = cam_pkg::col_t'(`H_VIS);
  localparam cam_pkg::col_t h_sync0 = cam_pkg::col_t'(`H_VIS + `H_FP);  // first sync clk
  localparam cam_pkg::col_t h_sync1 = cam_pkg::col_t'(`H_VIS + `H_FP + `H_SYNC);
  localparam cam_pkg::col_t h_last  =
    cam_pkg::col_t'(`H_VIS + `H_FP + `H_SYNC + `H_BP - 1);
  localparam cam_pkg::row_t v_vis   = cam_pkg::row_t'(`V_VIS);
  localparam cam_pkg::row_t v_sync0 = cam_pkg::row_t'(`V_VIS + `V_FP);
  localparam cam_pkg::row_t v_sync1 = cam_pkg::row_t'(`V_VIS + `V_FP + `V_SYNC);
  localparam cam_pkg::row_t v_last  =
    cam_pkg::row_t'(`V_VIS + `V_FP + `V_SYNC + `V_BP - 1);

  cam_pkg::col_t col_q, col_nxt;
  cam_pkg::row_t row_q, row_nxt;
  logic          hs_q, vs_q, vis_q;

  // next position, decoded flags use it so they line up with the counters
  always_comb begin
    col_nxt = col_q + 1'b1;
    row_nxt = row_q;
    if (col_q == h_last) begin
      col_nxt = '0;
      row_nxt = (row_q == v_last) ? '0 : row_q + 1'b1;
    end
  end

  // reset parks the raster on its very last clk, first visible pixel follows
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      col_q <= h_last;
      row_q <= v_last;
      hs_q  <= 1'b1;
      vs_q  <= 1'b1;
      vis_q <= 1'b0;
    end else begin
      col_q <= col_nxt;
      row_q <= row_nxt;
      hs_q  <= !((col_nxt >= h_sync0) && (col_nxt < h_sync1));
      vs_q  <= !((row_nxt >= v_sync0) && (row_nxt < v_sync1));
      vis_q <= (col_nxt < h_vis) && (row_nxt < v_vis);
    end
  end

  assign tim.col     = col_q;
  assign tim.row     = row_q;
  assign tim.hsync   = hs_q;
  assign tim.vsync   = vs_q;
  assign tim.visible = vis_q;

  a_col_range : assert property (@(posedge clk) disable iff (!arst_n)
    tim.col <= h_last)
    else $error("raster column beyond line total");

endmodule

// File: display/vga_display.sv
// ##########################################################################
// raster display
// buffer address from raster position with 2x upscale, sync delayed to
// match the memory read, colour bar test pattern on test_mode
// ##########################################################################
`timescale 1ns/1ps
`include "cam_settings.svh"

module vga_display (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               test_mode,
  vga_timing_if.snk          tim,
  output cam_pkg::img_addr_t rd_addr,
  input  cam_pkg::pixel_t    rd_data,
  output logic [3:0]         vga_red,
  output logic [3:0]         vga_green,
  output logic [3:0]         vga_blue,
  output logic               hsync,
  output logic               vsync,
  output logic               de
);

  localparam int bar_w = `H_VIS / 8;  // eight bars across the line

  cam_pkg::col_t      img_col;   // raster col scaled down to image col
  cam_pkg::row_t      img_row;
  cam_pkg::img_addr_t addr_nxt;
  logic [2:0]         bar_nxt, bar1, bar2;  // bar index, bits select r/g/b
  logic               hs1, vs1, vis1;       // stage 1: address register
  logic               hs2, vs2, de2;        // stage 2: memory read

  always_comb begin
    img_col  = cam_pkg::col_t'(tim.col / `IMG_SCALE);
    img_row  = cam_pkg::row_t'(tim.row / `IMG_SCALE);
    addr_nxt = '0;  // stay in range during blanking
    if (tim.visible)
      addr_nxt = cam_pkg::img_addr_t'(img_row) * cam_pkg::img_addr_t'(`IMG_COLS)
               + cam_pkg::img_addr_t'(img_col);
    bar_nxt  = 3'(tim.col / bar_w);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hs1  <= 1'b1;
      vs1  <= 1'b1;
      vis1 <= 1'b0;
      hs2  <= 1'b1;
      vs2  <= 1'b1;
      de2  <= 1'b0;
    end else begin
      hs1  <= tim.hsync;
      vs1  <= tim.vsync;
      vis1 <= tim.visible;
      hs2  <= hs1;
      vs2  <= vs1;
      de2  <= vis1;
    end
  end

  always_ff @(posedge clk) begin
    rd_addr <= addr_nxt;
    bar1    <= bar_nxt;
    bar2    <= bar1;  // same delay as rd_data
  end

  assign hsync = hs2;
  assign vsync = vs2;
  assign de    = de2;

  // black outside the active area
  always_comb begin
    vga_red   = '0;
    vga_green = '0;
    vga_blue  = '0;
    if (de2) begin
      if (test_mode) begin
        vga_red   = {4{bar2[2]}};
        vga_green = {4{bar2[1]}};
        vga_blue  = {4{bar2[0]}};
      end else begin
        vga_red   = rd_data.red;
        vga_green = rd_data.green;
        vga_blue  = rd_data.blue;
      end
    end
  end

  a_de_no_sync : assert property (@(posedge clk) disable iff (!arst_n)
    de |-> (hsync && vsync))
    else $error("display enable high during sync pulse");

endmodule

// File: design/cam_vga_top.sv
// ##########################################################################
// camera to display top level
// capture into 80x60 buffer, read back 2x upscaled onto the raster
// ##########################################################################
`timescale 1ns/1ps

module cam_vga_top (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       test_mode,   // colour bars instead of image
  input  logic       cam_pclk,
  input  logic       cam_href,
  input  logic       cam_vsync,
  input  logic [7:0] cam_data,
  output logic [3:0] vga_red,
  output logic [3:0] vga_green,
  output logic [3:0] vga_blue,
  output logic       vga_hsync,
  output logic       vga_vsync,
  output logic       vga_de,
  output logic [7:0] frame_cnt    // finished camera frames
);

  logic               cap_wr_en;
  cam_pkg::img_addr_t cap_wr_addr;
  cam_pkg::pixel_t    cap_wr_data;
  cam_pkg::img_addr_t fb_rd_addr;
  cam_pkg::pixel_t    fb_rd_data;

  vga_timing_if tim ();

  ov7670_capture u_capture (
    .clk       (clk),
    .arst_n    (arst_n),
    .pclk      (cam_pclk),
    .href      (cam_href),
    .vsync     (cam_vsync),
    .data      (cam_data),
    .wr_en     (cap_wr_en),
    .wr_addr   (cap_wr_addr),
    .wr_data   (cap_wr_data),
    .frame_cnt (frame_cnt)
  );

  frame_buffer u_fb (
    .clk     (clk),
    .wr_en   (cap_wr_en),
    .wr_addr (cap_wr_addr),
    .wr_data (cap_wr_data),
    .rd_addr (fb_rd_addr),
    .rd_data (fb_rd_data)
  );

  vga_sync u_sync (
    .clk    (clk),
    .arst_n (arst_n),
    .tim    (tim.src)
  );

  vga_display u_display (
    .clk       (clk),
    .arst_n    (arst_n),
    .test_mode (test_mode),
    .tim       (tim.snk),
    .rd_addr   (fb_rd_addr),
    .rd_data   (fb_rd_data),
    .vga_red   (vga_red),
    .vga_green (vga_green),
    .vga_blue  (vga_blue),
    .hsync     (vga_hsync),
    .vsync     (vga_vsync),
    .de        (vga_de)
  );

endmodule

// File: testbench/ov7670_model.sv
// ##########################################################################
// behavioural ov7670 camera
// sends frames of rgb444 byte pairs from its pixel array on request
// ##########################################################################
`timescale 1ns/1ps
`include "cam_settings.svh"

module ov7670_model (
  input  logic       clk,
  input  logic       start,     // one clk pulse starts a frame
  input  logic [6:0] n_lines,   // href lines in this frame, 0 gives vsync only
  output logic       busy,
  output logic       pclk,
  output logic       href,
  output logic       vsync,
  output logic [7:0] data
);

  localparam int line_pclks = 2 * `IMG_COLS + 4;  // bytes plus gap

  cam_pkg::pixel_t pix [0:`IMG_PXLS-1];  // filled by the testbench

  // pclk is clk / 8, edges just after the clk edge like every other input
  initial begin
    pclk = 1'b0;
    forever begin
      repeat (4) @(posedge clk);
      #10 pclk = ~pclk;
    end
  end

  task automatic send_line(input int r);
    cam_pkg::pixel_t p;
    int              c;
    repeat (4) begin  // gap with href low
      @(negedge pclk);
      href = 1'b0;
      data = 8'h00;
    end
    for (c = 0; c < `IMG_COLS; c++) begin
      p = pix[r * `IMG_COLS + c];
      @(negedge pclk);
      href = 1'b1;
      data = {~p.red, p.red};  // upper nibble unused by capture
      @(negedge pclk);
      data = {p.green, p.blue};
    end
  endtask

  initial begin
    busy  = 1'b0;
    href  = 1'b0;
    vsync = 1'b0;
    data  = 8'h00;
    forever begin
      @(posedge clk);
      if (start) begin
        busy = 1'b1;
        @(negedge pclk);
        vsync = 1'b1;
        repeat (3 * line_pclks) @(negedge pclk);  // 3 line vsync pulse
        vsync = 1'b0;
        for (int r = 0; r < n_lines; r++)
          send_line(r);
        @(negedge pclk);
        href = 1'b0;
        data = 8'h00;
        repeat (3) @(negedge pclk);  // lets the last write land
        busy = 1'b0;
      end
    end
  end

endmodule

// File: testbench/tb_cam_vga.sv
// ##########################################################################
// camera to display testbench
// random camera frames in, upscaled raster frames checked pixel by pixel
// ##########################################################################
`timescale 1ns/1ps
`include "cam_settings.svh"

module tb_cam_vga;

  localparam int cam_frame_clks = (3 + `IMG_ROWS) * (2 * `IMG_COLS + 4) * 8;
  localparam int ras_frame_clks = (`H_VIS + `H_FP + `H_SYNC + `H_BP)
                                * (`V_VIS + `V_FP + `V_SYNC + `V_BP);

  logic       clk, arst_n, test_mode;
  logic       cam_pclk, cam_href, cam_vsync;
  logic [7:0] cam_data;
  logic [3:0] vga_red, vga_green, vga_blue;
  logic       vga_hsync, vga_vsync, vga_de;
  logic [7:0] frame_cnt;
  logic       start, busy;
  logic [6:0] n_lines;
  logic       cmp_req;   // main asks compare process for one raster frame
  logic       cmp_mode;  // test_mode value the frame is checked against

  cam_pkg::pixel_t ref_img [0:`IMG_PXLS-1];  // expected buffer contents

  cam_vga_top uut (
    .clk (clk), .arst_n (arst_n), .test_mode (test_mode),
    .cam_pclk (cam_pclk), .cam_href (cam_href), .cam_vsync (cam_vsync),
    .cam_data (cam_data),
    .vga_red (vga_red), .vga_green (vga_green), .vga_blue (vga_blue),
    .vga_hsync (vga_hsync), .vga_vsync (vga_vsync), .vga_de (vga_de),
    .frame_cnt (frame_cnt)
  );

  ov7670_model cam (
    .clk (clk), .start (start), .n_lines (n_lines), .busy (busy),
    .pclk (cam_pclk), .href (cam_href), .vsync (cam_vsync), .data (cam_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // colour bars by bar index, otherwise the 2x upscaled image
  function automatic logic [11:0] expected_pixel(input int row, input int col, input bit tm);
    logic [2:0] bar;
    bar = 3'(col / (`H_VIS / 8));
    if (tm)
      return {{4{bar[2]}}, {4{bar[1]}}, {4{bar[0]}}};
    return ref_img[(row / `IMG_SCALE) * `IMG_COLS + col / `IMG_SCALE];
  endfunction

  task automatic fill_image();
    logic [11:0] v;
    for (int i = 0; i < `IMG_PXLS; i++) begin
      v = 12'($urandom);
      cam.pix[i] = v;
    end
  endtask

  // a frame of n lines overwrites only the first n image rows
  task automatic update_ref(input int n);
    cam_pkg::pixel_t p;
    for (int i = 0; i < n * `IMG_COLS; i++) begin
      p = cam.pix[i];
      if (`SWAP_R_B != 0)
        ref_img[i] = '{red: p.blue, green: p.green, blue: p.red};
      else
        ref_img[i] = p;
    end
  endtask

  task automatic play_frame(input int n);
    @(posedge clk);
    #10 n_lines = 7'(n);
    start = 1'b1;
    @(posedge clk);
    #10 start = 1'b0;
    while (busy) @(posedge clk);
  endtask

  task automatic check_raster(input bit tm);
    cmp_mode = tm;
    cmp_req  = 1'b1;
    wait (!cmp_req);
  endtask

  // compare process, samples at negedge where all outputs are settled
  initial begin : compare
    int   row, col, hs_len;
    logic prev_de, prev_vs, done;
    forever begin
      wait (cmp_req);
      @(negedge clk);
      do begin  // find the start of a frame
        prev_vs = vga_vsync;
        @(negedge clk);
      end while (!(prev_vs && !vga_vsync));
      row = 0;
      col = 0;
      hs_len = 0;
      prev_de = 1'b0;
      done = 1'b0;
      while (!done) begin
        prev_vs = vga_vsync;
        @(negedge clk);
        if (vga_de) begin
          if (!vga_hsync || !vga_vsync)
            abort_run("vga_de was high during a sync pulse");
          check($sformatf("vga_rgb at row %0d col %0d", row, col),
                {vga_red, vga_green, vga_blue}, expected_pixel(row, col, cmp_mode));
          col++;
        end else begin
          check("vga_rgb outside de", {vga_red, vga_green, vga_blue}, 0);  // black
          if (prev_de) begin  // end of a visible line
            check("vga_de cycles per line", col, `H_VIS);
            row++;
            col = 0;
          end
        end
        if (!vga_hsync)
          hs_len++;
        else if (hs_len != 0) begin
          check("vga_hsync low width", hs_len, `H_SYNC);
          hs_len = 0;
        end
        prev_de = vga_de;
        done = prev_vs && !vga_vsync;  // next frame begins
      end
      check("vga_de lines per frame", row, `V_VIS);
      cmp_req = 1'b0;
    end
  end

  initial begin : watchdog
    repeat (6 * cam_frame_clks + 6 * ras_frame_clks) @(posedge clk);
    abort_run("timeout: the test sequence did not finish in the allowed time");
  end

  initial begin : main
    void'($urandom(32'he803));
    arst_n    = 1'b0;
    test_mode = 1'b0;
    start     = 1'b0;
    n_lines   = '0;
    cmp_req   = 1'b0;
    cmp_mode  = 1'b0;
    repeat (8) begin  // outputs idle during reset
      @(negedge clk);
      check("vga_de", vga_de, 0);
      check("vga_hsync", vga_hsync, 1);
      check("vga_vsync", vga_vsync, 1);
      check("frame_cnt", frame_cnt, 0);
    end
    @(posedge clk);
    #10 arst_n = 1'b1;
    fill_image();  // first image, geometry and pixels
    play_frame(`IMG_ROWS);
    check("frame_cnt", frame_cnt, 0);  // nothing written before first vsync
    update_ref(`IMG_ROWS);
    check_raster(1'b0);
    fill_image();  // second image replaces the first
    play_frame(`IMG_ROWS);
    play_frame(0);  // vsync only, closes the frame
    check("frame_cnt", frame_cnt, 2);
    update_ref(`IMG_ROWS);
    check_raster(1'b0);
    @(posedge clk);
    #10 test_mode = 1'b1;
    check_raster(1'b1);
    @(posedge clk);
    #10 test_mode = 1'b0;
    check_raster(1'b0);
    fill_image();  // cut short after 20 lines
    play_frame(20);
    update_ref(20);
    check_raster(1'b0);
    fill_image();  // full frame after the short one
    play_frame(`IMG_ROWS);
    check("frame_cnt", frame_cnt, 3);
    update_ref(`IMG_ROWS);
    check_raster(1'b0);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+common
common/cam_pkg.sv
common/vga_timing_if.sv
capture/ov7670_capture.sv
design/frame_buffer.sv
display/vga_sync.sv
display/vga_display.sv
design/cam_vga_top.sv
testbench/ov7670_model.sv
testbench/tb_cam_vga.sv

// File: run.sh
#!/bin/sh
# build and run the camera to display testbench with verilator
# the log is searched for the fail message to decide the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cam_vga \
  -f vlog.f > sim.log 2>&1 || { echo "build failed, see sim.log"; exit 1; }
./obj_dir/Vtb_cam_vga >> sim.log 2>&1 ||
  echo "CHECKS FAILED: simulator exited with an error" >> sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
